// ==== spw_tx.f ====
src/spw_tx_pkg.sv
src/spw_char_encoder.sv
src/spw_bit_shifter.sv
src/spw_ds_encoder.sv
src/spw_tx.sv
tests/spw_ds_monitor.sv
tests/tb_spw_tx.sv

// ==== Makefile ====
# Verilator build and run for the SpaceWire transmitter testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_spw_tx
FILELIST  ?= spw_tx.f
BUILD_DIR ?= obj_dir
TIMESCALE ?= 1ns/100ps
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= Everything OK

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up as a line of its own
run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/tb_spw_tx.sv ====
// ----------------------------------------------------------
// SpaceWire TX testbench
// Directed character streams checked against a bit-level model
// ----------------------------------------------------------
module tb_spw_tx
	import spw_tx_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CLK_HALF     = 10;
	localparam int DRIVE_DELAY  = 2;
	localparam int RESET_CYCLES = 16;
	localparam int IDLE_CYCLES  = 20;
	localparam int HOLD_CYCLES  = 6;
	localparam int N_NULL       = 12;
	localparam int N_DATA       = 32;
	localparam int N_CTRL       = 2 * 4 * 4;
	localparam int N_TIMEC      = 16;
	localparam int N_CHARS      = N_NULL + N_DATA + N_CTRL + N_TIMEC;
	localparam int TIMEOUT_CYCLES = N_CHARS * SPW_MAX_BITS + 400;

	localparam logic [31:0] LFSR_SEED = 32'h2a4b9b39;
	localparam logic [31:0] LFSR_TAPS = 32'h80200003;

	logic      pclk_tx;
	logic      enable_tx;
	logic      send_null;
	spw_char_t next_char;
	logic      char_take;
	logic      dout;
	logic      sout;
	logic      rx_valid;
	logic      rx_bit;
	int        line_errors;

	// Model and scoreboard state of the clocked blocks
	logic      exp_q [$];
	logic      exp_bit;
	bit        bit_ok;
	logic      model_xor = 1'b0;
	logic      take_seen = 1'b0;
	spw_char_t take_char;
	int        takes = 0;
	int        bits_seen = 0;
	int        stream_checks = 0;
	int        stream_errors = 0;
	int        cycles = 0;

	// Stimulus state of the main initial block
	spw_char_t   src_q [$];
	logic [31:0] lfsr;
	int          test_checks = 0;
	int          test_errors = 0;

	spw_tx i_dut
	(
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.send_null (send_null),
		.next_char (next_char),
		.char_take (char_take),
		.dout      (dout),
		.sout      (sout)
	);

	spw_ds_monitor i_mon
	(
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.dout        (dout),
		.sout        (sout),
		.rx_valid    (rx_valid),
		.rx_bit      (rx_bit),
		.line_errors (line_errors)
	);

	initial
	begin
		pclk_tx = 1'b0;
		forever #CLK_HALF pclk_tx = ~pclk_tx;
	end

	always @(posedge pclk_tx)
	begin
		cycles = cycles + 1;
		if (cycles > TIMEOUT_CYCLES)
		begin
			$display("Timeout after %0d cycles, the tests did not finish", cycles);
			$display("Something failed");
			$finish;
		end
	end

	// ----------------------------------------------------------
	// Compare, model and helper routines
	// ----------------------------------------------------------
	task automatic compare_values(
		input  string       name,
		input  logic [31:0] actual,
		input  logic [31:0] expected,
		output bit          ok
	);
		ok = 1'b1;
		if (actual !== expected)
		begin
			$display("Error %s: got 0x%h, expected 0x%h", name, actual, expected);
			ok = 1'b0;
		end
	endtask

	task automatic note_check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		bit ok;
		test_checks = test_checks + 1;
		compare_values(name, actual, expected, ok);
		if (!ok)
			test_errors = test_errors + 1;
	endtask

	function automatic int total_errors();
		return test_errors + stream_errors + line_errors;
	endfunction

	// Parity makes parity ^ previous data bits ^ flag equal to 1
	task automatic push_ctrl(input logic [1:0] code);
		logic par;
		par = 1'b1 ^ model_xor ^ 1'b1;
		exp_q.push_back(par);
		exp_q.push_back(1'b1);
		exp_q.push_back(code[1]);
		exp_q.push_back(code[0]);
		model_xor = code[1] ^ code[0];
	endtask

	task automatic push_data(input logic [7:0] value);
		logic par;
		par = 1'b1 ^ model_xor ^ 1'b0;
		exp_q.push_back(par);
		exp_q.push_back(1'b0);
		for (int i = 0; i < 8; i++)
			exp_q.push_back(value[i]);
		model_xor = ^value;
	endtask

	task automatic model_char(input spw_char_t c);
		case (c.kind)
		SPW_NULL:
		begin
			push_ctrl(SPW_CODE_ESC);
			push_ctrl(SPW_CODE_FCT);
		end
		SPW_FCT:   push_ctrl(SPW_CODE_FCT);
		SPW_EOP:   push_ctrl(SPW_CODE_EOP);
		SPW_EEP:   push_ctrl(SPW_CODE_EEP);
		SPW_DATA:  push_data(c.data);
		SPW_TIMEC:
		begin
			push_ctrl(SPW_CODE_ESC);
			push_data(c.data);
		end
		default:
		begin
			$display("Character of unknown kind was taken by the DUT");
			stream_errors = stream_errors + 1;
		end
		endcase
	endtask

	function automatic logic [31:0] lfsr_step(input logic [31:0] state);
		if (state[0])
			return (state >> 1) ^ LFSR_TAPS;
		return state >> 1;
	endfunction

	task automatic draw_byte(output logic [7:0] value);
		for (int i = 0; i < 8; i++)
		begin
			lfsr = lfsr_step(lfsr);
			value[i] = lfsr[0];
		end
	endtask

	function automatic spw_char_t make_char(input spw_char_kind_e kind, input logic [7:0] data);
		spw_char_t c;
		c.kind = kind;
		c.data = data;
		return c;
	endfunction

	// Only DATA and TIMEC carry a value worth drawing
	task automatic queue_kind(input spw_char_kind_e kind);
		logic [7:0] value;
		value = 8'h00;
		if ((kind == SPW_DATA) || (kind == SPW_TIMEC))
			draw_byte(value);
		src_q.push_back(make_char(kind, value));
	endtask

	// ----------------------------------------------------------
	// Scoreboard
	// ----------------------------------------------------------
	always @(negedge pclk_tx)
	begin
		take_seen <= enable_tx && char_take;
		take_char <= next_char;
	end

	always @(posedge pclk_tx)
	begin
		if (take_seen)
		begin
			takes = takes + 1;
			model_char(take_char);
		end
		if (rx_valid)
		begin
			bits_seen = bits_seen + 1;
			if (exp_q.size() == 0)
			begin
				$display("A bit was recovered while no character was expected");
				stream_errors = stream_errors + 1;
			end
			else
			begin
				exp_bit = exp_q.pop_front();
				stream_checks = stream_checks + 1;
				compare_values("dout bit", 32'(rx_bit), 32'(exp_bit), bit_ok);
				if (!bit_ok)
					stream_errors = stream_errors + 1;
			end
		end
	end

	// ----------------------------------------------------------
	// Stimulus
	// ----------------------------------------------------------
	task automatic send_queue();
		@(posedge pclk_tx);
		#DRIVE_DELAY;
		while (src_q.size() > 0)
		begin
			next_char = src_q.pop_front();
			send_null = 1'b1;
			@(negedge pclk_tx);
			while (!char_take)
				@(negedge pclk_tx);
			@(posedge pclk_tx);
			#DRIVE_DELAY;
		end
		// Lines hold once the current character finishes
		send_null = 1'b0;
	endtask

	task automatic drain_line();
		logic hold_dout;
		logic hold_sout;
		while (exp_q.size() != 0)
			@(posedge pclk_tx);
		@(negedge pclk_tx);
		hold_dout = dout;
		hold_sout = sout;
		repeat (HOLD_CYCLES) @(negedge pclk_tx);
		note_check("dout", 32'(dout), 32'(hold_dout));
		note_check("sout", 32'(sout), 32'(hold_sout));
	endtask

	task automatic report_test(input string name, input int errs_before);
		$display("%s finished with %0d errors", name, total_errors() - errs_before);
	endtask

	// ----------------------------------------------------------
	// Directed tests
	// ----------------------------------------------------------
	task automatic reset_and_idle();
		int errs;
		errs = total_errors();
		repeat (IDLE_CYCLES)
		begin
			@(negedge pclk_tx);
			note_check("dout", 32'(dout), 32'h0);
			note_check("sout", 32'(sout), 32'h0);
			note_check("char_take", 32'(char_take), 32'h0);
		end
		note_check("recovered bits", 32'(bits_seen), 32'h0);
		report_test("reset and idle", errs);
	endtask

	task automatic null_stream();
		int errs;
		int takes0;
		int bits0;
		errs = total_errors();
		takes0 = takes;
		bits0 = bits_seen;
		repeat (N_NULL) queue_kind(SPW_NULL);
		send_queue();
		drain_line();
		note_check("char_take count", 32'(takes - takes0), 32'(N_NULL));
		// Eight bits per NULL
		note_check("null bits", 32'(bits_seen - bits0), 32'(8 * N_NULL));
		report_test("null stream", errs);
	endtask

	task automatic data_chars();
		int errs;
		errs = total_errors();
		repeat (N_DATA) queue_kind(SPW_DATA);
		send_queue();
		drain_line();
		report_test("data characters", errs);
	endtask

	task automatic control_chars();
		int errs;
		spw_char_kind_e kinds [4];
		errs = total_errors();
		kinds = '{SPW_FCT, SPW_EOP, SPW_EEP, SPW_DATA};
		// Every ordered pair of kinds covers the parity chain
		for (int a = 0; a < 4; a++)
		begin
			for (int b = 0; b < 4; b++)
			begin
				queue_kind(kinds[a]);
				queue_kind(kinds[b]);
			end
		end
		send_queue();
		drain_line();
		report_test("control characters", errs);
	endtask

	task automatic time_codes();
		int errs;
		errs = total_errors();
		repeat (N_TIMEC) queue_kind(SPW_TIMEC);
		send_queue();
		drain_line();
		report_test("time-codes", errs);
	endtask

	initial
	begin
		enable_tx = 1'b0;
		send_null = 1'b0;
		next_char = make_char(SPW_NULL, 8'h00);
		lfsr = LFSR_SEED;
		repeat (RESET_CYCLES) @(posedge pclk_tx);
		#DRIVE_DELAY;
		enable_tx = 1'b1;

		reset_and_idle();
		null_stream();
		data_chars();
		control_chars();
		time_codes();

		$display("checks %0d, errors %0d", test_checks + stream_checks, total_errors());
		if (total_errors() == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

// ==== tests/spw_ds_monitor.sv ====
// ----------------------------------------------------------
// Data/strobe line monitor
// Recovers bits and flags cycles where both lines change
// ----------------------------------------------------------
module spw_ds_monitor
(
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic dout,
	input  logic sout,
	output logic rx_valid,
	output logic rx_bit,
	output int   line_errors
);
	timeunit 1ns;
	timeprecision 100ps;

	logic prev_dout;
	logic prev_sout;

	// Lines change on the rising edge, so look at them on the falling one
	always @(negedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			prev_dout   <= 1'b0;
			prev_sout   <= 1'b0;
			rx_valid    <= 1'b0;
			rx_bit      <= 1'b0;
			line_errors <= 0;
		end
		else
		begin
			// A new bit whenever the XOR of the two lines flips
			rx_valid <= (dout ^ sout) != (prev_dout ^ prev_sout);
			rx_bit   <= dout;
			if ((dout != prev_dout) && (sout != prev_sout))
			begin
				$display("Data and strobe lines both changed in one cycle at %0t", $time);
				line_errors <= line_errors + 1;
			end
			prev_dout <= dout;
			prev_sout <= sout;
		end
	end

endmodule

// ==== src/spw_tx.sv ====
// ----------------------------------------------------------
// SpaceWire link transmitter top
// Character encoder, bit shifter and data/strobe encoder
// ----------------------------------------------------------
module spw_tx
	import spw_tx_pkg::*;
(
	input  logic      pclk_tx,
	input  logic      enable_tx,
	input  logic      send_null,
	input  spw_char_t next_char,
	output logic      char_take,
	output logic      dout,
	output logic      sout
);

	spw_pattern_t pattern;
	logic         prev_parity;
	logic         bit_out;
	logic         bit_valid;

	spw_char_encoder u_char_encoder
	(
		.next_char   (next_char),
		.prev_parity (prev_parity),
		.pattern     (pattern)
	);

	spw_bit_shifter u_bit_shifter
	(
		.pclk_tx     (pclk_tx),
		.enable_tx   (enable_tx),
		.send_null   (send_null),
		.pattern     (pattern),
		.prev_parity (prev_parity),
		.char_take   (char_take),
		.bit_out     (bit_out),
		.bit_valid   (bit_valid)
	);

	// One cycle from shifter output to the lines
	spw_ds_encoder u_ds_encoder
	(
		.pclk_tx   (pclk_tx),
		.enable_tx (enable_tx),
		.bit_out   (bit_out),
		.bit_valid (bit_valid),
		.dout      (dout),
		.sout      (sout)
	);

endmodule

// ==== src/spw_ds_encoder.sv ====
// ----------------------------------------------------------
// SpaceWire data/strobe encoder
// ----------------------------------------------------------
module spw_ds_encoder
(
	input  logic pclk_tx,
	input  logic enable_tx,
	input  logic bit_out,
	input  logic bit_valid,
	output logic dout,
	output logic sout
);

	logic sout_next;

	// Strobe changes only when data repeats
	assign sout_next = (bit_out == dout) ? ~sout : sout;

	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			dout <= 1'b0;
			sout <= 1'b0;
		end
		else if (bit_valid)
		begin
			dout <= bit_out;
			sout <= sout_next;
		end
	end

endmodule

// ==== src/spw_bit_shifter.sv ====
// ----------------------------------------------------------
// SpaceWire TX bit shifter
// Loads characters back to back and sends one bit per cycle
// ----------------------------------------------------------
module spw_bit_shifter
	import spw_tx_pkg::*;
(
	input  logic         pclk_tx,
	input  logic         enable_tx,
	input  logic         send_null,
	input  spw_pattern_t pattern,
	output logic         prev_parity,
	output logic         char_take,
	output logic         bit_out,
	output logic         bit_valid
);

	spw_shift_state_e        state;
	logic [SPW_MAX_BITS-1:0] shift_reg;
	logic [SPW_LEN_W-1:0]    bit_cnt;
	logic                    last_bit;

	// ----------------------------------------------------------
	// Load control
	// ----------------------------------------------------------
	// Counter holds the number of bits left after the current one
	assign last_bit = (state == SHIFT_SEND) && (bit_cnt == '0);

	// Load when empty or on the last bit, so characters follow with no gap
	assign char_take = send_null && ((state == SHIFT_IDLE) || last_bit);

	assign bit_valid = (state == SHIFT_SEND);
	assign bit_out   = bit_valid & shift_reg[0];

	// ----------------------------------------------------------
	// State, counter and chained parity
	// ----------------------------------------------------------
	always_ff @(posedge pclk_tx or negedge enable_tx)
	begin
		if (!enable_tx)
		begin
			state       <= SHIFT_IDLE;
			bit_cnt     <= '0;
			prev_parity <= 1'b0;
		end
		else if (char_take)
		begin
			state       <= SHIFT_SEND;
			bit_cnt     <= pattern.len - SPW_LEN_W'(1);
			prev_parity <= pattern.next_parity;
		end
		else if (last_bit)
		begin
			// Source stopped, lines hold after this bit
			state <= SHIFT_IDLE;
		end
		else if (state == SHIFT_SEND)
		begin
			bit_cnt <= bit_cnt - SPW_LEN_W'(1);
		end
	end

	// ----------------------------------------------------------
	// Shift register
	// ----------------------------------------------------------
	// Bit 0 is the bit on the line this cycle
	always_ff @(posedge pclk_tx)
	begin
		if (char_take)
		begin
			shift_reg <= pattern.bits;
		end
		else if (state == SHIFT_SEND)
		begin
			shift_reg <= {1'b0, shift_reg[SPW_MAX_BITS-1:1]};
		end
	end

endmodule

// ==== src/spw_char_encoder.sv ====
// ----------------------------------------------------------
// SpaceWire TX character encoder
// Builds bit pattern, length and chained parity of a character
// ----------------------------------------------------------
module spw_char_encoder
	import spw_tx_pkg::*;
(
	input  spw_char_t    next_char,
	input  logic         prev_parity,
	output spw_pattern_t pattern
);

	// XOR of the ESC code bits, seen by the character after ESC
	localparam logic ESC_XOR = ^SPW_CODE_ESC;

	logic [1:0] ctrl_code;

	// ----------------------------------------------------------
	// Helpers
	// ----------------------------------------------------------
	// Parity bit that makes parity, previous data and flag odd
	function automatic logic parity_bit(
		input logic prev_xor,
		input logic flag
	);
		return ~(prev_xor ^ flag);
	endfunction

	// Control character, parity first then flag then code
	function automatic logic [3:0] ctrl_bits(
		input logic       prev_xor,
		input logic [1:0] code
	);
		logic par;
		par = parity_bit(prev_xor, 1'b1);
		return {code[0], code[1], 1'b1, par};
	endfunction

	// Data character, byte goes out LSB first
	function automatic logic [9:0] data_bits(
		input logic       prev_xor,
		input logic [7:0] value
	);
		logic par;
		par = parity_bit(prev_xor, 1'b0);
		return {value, 1'b0, par};
	endfunction

	// ----------------------------------------------------------
	// Code selection for FCT, EOP and EEP
	// ----------------------------------------------------------
	always_comb
	begin
		case (next_char.kind)
		SPW_EOP:
		begin
			ctrl_code = SPW_CODE_EOP;
		end
		SPW_EEP:
		begin
			ctrl_code = SPW_CODE_EEP;
		end
		default:
		begin
			ctrl_code = SPW_CODE_FCT;
		end
		endcase
	end

	// ----------------------------------------------------------
	// Pattern build
	// ----------------------------------------------------------
	always_comb
	begin
		pattern = '0;
		case (next_char.kind)
		SPW_FCT, SPW_EOP, SPW_EEP:
		begin
			pattern.bits        = SPW_MAX_BITS'(ctrl_bits(prev_parity, ctrl_code));
			pattern.len         = SPW_LEN_CTRL;
			pattern.next_parity = ^ctrl_code;
		end
		SPW_DATA:
		begin
			pattern.bits        = SPW_MAX_BITS'(data_bits(prev_parity, next_char.data));
			pattern.len         = SPW_LEN_DATA;
			pattern.next_parity = ^next_char.data;
		end
		SPW_TIMEC:
		begin
			// ESC, then a data character carrying the time value
			pattern.bits        = {data_bits(ESC_XOR, next_char.data),
			                       ctrl_bits(prev_parity, SPW_CODE_ESC)};
			pattern.len         = SPW_LEN_TIMEC;
			pattern.next_parity = ^next_char.data;
		end
		default:
		begin
			// NULL is ESC followed by FCT
			pattern.bits        = SPW_MAX_BITS'({ctrl_bits(ESC_XOR, SPW_CODE_FCT),
			                                     ctrl_bits(prev_parity, SPW_CODE_ESC)});
			pattern.len         = SPW_LEN_NULL;
			pattern.next_parity = ^SPW_CODE_FCT;
		end
		endcase
	end

endmodule

// ==== src/spw_tx_pkg.sv ====
// ----------------------------------------------------------
// SpaceWire TX shared definitions
// Character kinds, lengths, control codes and structs
// ----------------------------------------------------------
package spw_tx_pkg;

	// ----------------------------------------------------------
	// Sizes
	// ----------------------------------------------------------
	localparam int SPW_MAX_BITS = 14;
	localparam int SPW_LEN_W    = 4;

	// Bits per character, parity and flag included
	localparam logic [SPW_LEN_W-1:0] SPW_LEN_NULL  = 4'd8;
	localparam logic [SPW_LEN_W-1:0] SPW_LEN_CTRL  = 4'd4;
	localparam logic [SPW_LEN_W-1:0] SPW_LEN_DATA  = 4'd10;
	localparam logic [SPW_LEN_W-1:0] SPW_LEN_TIMEC = 4'd14;

	// ----------------------------------------------------------
	// Control codes
	// ----------------------------------------------------------
	// Sent after the flag in written order, high bit first
	localparam logic [1:0] SPW_CODE_FCT = 2'b00;
	localparam logic [1:0] SPW_CODE_EOP = 2'b01;
	localparam logic [1:0] SPW_CODE_EEP = 2'b10;
	localparam logic [1:0] SPW_CODE_ESC = 2'b11;

	// ----------------------------------------------------------
	// Types
	// ----------------------------------------------------------
	typedef enum logic [2:0] {
		SPW_NULL  = 3'd0,
		SPW_FCT   = 3'd1,
		SPW_EOP   = 3'd2,
		SPW_EEP   = 3'd3,
		SPW_DATA  = 3'd4,
		SPW_TIMEC = 3'd5
	} spw_char_kind_e;

	// Shifter states
	typedef enum logic {
		SHIFT_IDLE = 1'b0,
		SHIFT_SEND = 1'b1
	} spw_shift_state_e;

	// Data holds the byte for DATA and the time value for TIMEC
	typedef struct packed {
		spw_char_kind_e kind;
		logic [7:0]     data;
	} spw_char_t;

	// Bit 0 of bits leaves the link first
	typedef struct packed {
		logic [SPW_MAX_BITS-1:0] bits;
		logic [SPW_LEN_W-1:0]    len;
		logic                    next_parity;
	} spw_pattern_t;

endpackage
